// ==== dv/tb_io_buffer.sv ====
`timescale 1ns/1ps

module tb_io_buffer;
  import iob_pkg::*;

  // ------------------------------
  // run length
  // ------------------------------
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 4;
  localparam int POOL_SIZE    = 16;
  localparam int PAD_CYCLES   = 6;
  localparam int MIX_CYCLES   = 64;
  localparam int TAIL_CYCLES  = 3;
  localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 6 * POOL_SIZE + PAD_CYCLES +
                                MIX_CYCLES + TAIL_CYCLES;
  localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES + 100;

  // dut ports
  logic  i_clk = 1'b0;
  logic  i_rst_n;
  addr_t i_iob_bramctl_addr;
  logic  i_iob_bramctl_en;
  word_t o_iob_bramctl_rdata;
  be_t   i_iob_bramctl_be;
  logic  i_iob_bramctl_we;
  word_t i_iob_bramctl_wdata;
  addr_t i_iob_raddr;
  logic  i_iob_rd_en;
  logic  i_iob_pad_en;
  addr_t i_iob_waddr;
  logic  i_iob_wr_en;
  word_t i_iob_wdat;
  word_t o_mdata;
  logic  o_mdata_vld;

  // reference model and expected results
  logic [31:0] lfsr_state;
  word_t       model_mem [2 ** ADDR_BITS];
  addr_t       pool [POOL_SIZE];
  logic        pend_vld;
  word_t       pend_mdata;
  logic        pend_ext_vld;
  word_t       pend_ext_rdata;
  logic        exp_vld;
  word_t       exp_mdata;
  logic        exp_ext_vld;
  word_t       exp_ext_rdata;
  string       cur_test;
  string       exp_test;
  int          err_idle = 0;
  int          err_vld = 0;
  int          err_mdata = 0;
  int          err_ext = 0;
  int          cycle_count = 0;

  io_buffer u_dut (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_iob_bramctl_addr  (i_iob_bramctl_addr),
    .i_iob_bramctl_en    (i_iob_bramctl_en),
    .o_iob_bramctl_rdata (o_iob_bramctl_rdata),
    .i_iob_bramctl_be    (i_iob_bramctl_be),
    .i_iob_bramctl_we    (i_iob_bramctl_we),
    .i_iob_bramctl_wdata (i_iob_bramctl_wdata),
    .i_iob_raddr         (i_iob_raddr),
    .i_iob_rd_en         (i_iob_rd_en),
    .i_iob_pad_en        (i_iob_pad_en),
    .i_iob_waddr         (i_iob_waddr),
    .i_iob_wr_en         (i_iob_wr_en),
    .i_iob_wdat          (i_iob_wdat),
    .o_mdata             (o_mdata),
    .o_mdata_vld         (o_mdata_vld)
  );

  always #20 i_clk = ~i_clk;

  // ------------------------------
  // random source
  // ------------------------------

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);
    return lsb;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  // one pool entry that lives in the given bank
  function automatic int pool_slot(input int bank);
    return (bank % NUM_BANKS) + NUM_BANKS * int'(rand_bits(2));
  endfunction

  // bytes with their enable set take the new value
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t w;
    w = old_w;
    for (int i = 0; i < BE_BITS; i++) begin
      if (be[i]) begin
        w[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return w;
  endfunction

  // ------------------------------
  // request drivers
  // ------------------------------
  task automatic ext_write(input addr_t addr, input be_t be, input word_t data);
    i_iob_bramctl_en    = 1'b1;
    i_iob_bramctl_we    = 1'b1;
    i_iob_bramctl_addr  = addr;
    i_iob_bramctl_be    = be;
    i_iob_bramctl_wdata = data;
  endtask

  task automatic ext_read(input addr_t addr);
    i_iob_bramctl_en   = 1'b1;
    i_iob_bramctl_we   = 1'b0;
    i_iob_bramctl_addr = addr;
    pend_ext_vld       = 1'b1;
    pend_ext_rdata     = model_mem[addr];
  endtask

  task automatic int_write(input addr_t addr, input word_t data);
    i_iob_wr_en = 1'b1;
    i_iob_waddr = addr;
    i_iob_wdat  = data;
  endtask

  task automatic int_read(input addr_t addr);
    i_iob_rd_en = 1'b1;
    i_iob_raddr = addr;
    pend_vld    = 1'b1;
    pend_mdata  = i_iob_pad_en ? '0 : model_mem[addr];
  endtask

  // pad overrides a read in the same cycle
  task automatic pad_request();
    i_iob_pad_en = 1'b1;
    pend_vld     = 1'b1;
    pend_mdata   = '0;
  endtask

  // writes land in the model, then one clock passes
  task automatic next_cycle();
    if (i_iob_bramctl_en && i_iob_bramctl_we) begin
      model_mem[i_iob_bramctl_addr] = merge_bytes(model_mem[i_iob_bramctl_addr],
                                                  i_iob_bramctl_wdata, i_iob_bramctl_be);
    end
    if (i_iob_wr_en) begin
      model_mem[i_iob_waddr] = i_iob_wdat;
    end
    @(negedge i_clk);
    i_iob_bramctl_en = 1'b0;
    i_iob_bramctl_we = 1'b0;
    i_iob_rd_en      = 1'b0;
    i_iob_pad_en     = 1'b0;
    i_iob_wr_en      = 1'b0;
    pend_vld         = 1'b0;
    pend_mdata       = '0;
    pend_ext_vld     = 1'b0;
    pend_ext_rdata   = '0;
  endtask

  // expected results of the requests taken at this edge
  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      exp_vld       <= 1'b0;
      exp_mdata     <= '0;
      exp_ext_vld   <= 1'b0;
      exp_ext_rdata <= '0;
      exp_test      <= "reset";
    end else begin
      exp_vld       <= pend_vld;
      exp_mdata     <= pend_mdata;
      exp_ext_vld   <= pend_ext_vld;
      exp_ext_rdata <= pend_ext_rdata;
      exp_test      <= cur_test;
    end
  end

  // ------------------------------
  // checks, mid-cycle
  // ------------------------------
  a_idle_zero: assert property (@(negedge i_clk) disable iff (!i_rst_n)
    !exp_vld |-> (!o_mdata_vld && (o_mdata == '0)))
    else begin
      err_idle++;
      $display("Error: test %s, idle vld/mdata expected 0/0 actual %0b/%h",
               exp_test, o_mdata_vld, o_mdata);
    end

  a_mdata_vld: assert property (@(negedge i_clk) disable iff (!i_rst_n)
    exp_vld |-> o_mdata_vld)
    else begin
      err_vld++;
      $display("Error: test %s, o_mdata_vld expected 1 actual %0b", exp_test, o_mdata_vld);
    end

  a_mdata_value: assert property (@(negedge i_clk) disable iff (!i_rst_n)
    exp_vld |-> (o_mdata == exp_mdata))
    else begin
      err_mdata++;
      $display("Error: test %s, o_mdata expected %h actual %h", exp_test, exp_mdata, o_mdata);
    end

  a_ext_rdata: assert property (@(negedge i_clk) disable iff (!i_rst_n)
    exp_ext_vld |-> (o_iob_bramctl_rdata == exp_ext_rdata))
    else begin
      err_ext++;
      $display("Error: test %s, o_iob_bramctl_rdata expected %h actual %h",
               exp_test, exp_ext_rdata, o_iob_bramctl_rdata);
    end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int base;
    int total;
    lfsr_state          = 32'h5787;
    i_rst_n             = 1'b0;
    i_iob_bramctl_addr  = '0;
    i_iob_bramctl_en    = 1'b0;
    i_iob_bramctl_be    = '0;
    i_iob_bramctl_we    = 1'b0;
    i_iob_bramctl_wdata = '0;
    i_iob_raddr         = '0;
    i_iob_rd_en         = 1'b0;
    i_iob_pad_en        = 1'b0;
    i_iob_waddr         = '0;
    i_iob_wr_en         = 1'b0;
    i_iob_wdat          = '0;
    pend_vld            = 1'b0;
    pend_mdata          = '0;
    pend_ext_vld        = 1'b0;
    pend_ext_rdata      = '0;
    cur_test            = "idle";

    // entry j sits in bank j mod 4, so walking the pool changes bank every step
    for (int j = 0; j < POOL_SIZE; j++) begin
      pool[j] = {bank_sel_t'(j % NUM_BANKS), bank_addr_t'(rand_bits(BANK_ADDR_BITS))};
    end

    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst_n = 1'b1;
    repeat (IDLE_CYCLES) next_cycle();

    cur_test = "full_write_int_read";
    for (int j = 0; j < POOL_SIZE; j++) begin
      ext_write(pool[j], '1, rand_bits(WORD_BITS));
      next_cycle();
    end
    for (int j = 0; j < POOL_SIZE; j++) begin
      int_read(pool[j]);
      next_cycle();
    end

    cur_test = "byte_enable_write";
    for (int j = 0; j < POOL_SIZE; j++) begin
      ext_write(pool[j], be_t'(rand_bits(BE_BITS)), rand_bits(WORD_BITS));
      next_cycle();
    end
    for (int j = 0; j < POOL_SIZE; j++) begin
      int_read(pool[j]);
      next_cycle();
    end

    cur_test = "int_write_ext_read";
    for (int j = 0; j < POOL_SIZE; j++) begin
      int_write(pool[j], rand_bits(WORD_BITS));
      next_cycle();
    end
    for (int j = 0; j < POOL_SIZE; j++) begin
      ext_read(pool[j]);
      next_cycle();
    end

    cur_test = "pad";
    pad_request();
    next_cycle();
    pad_request();
    int_read(pool[1]);
    next_cycle();
    int_read(pool[2]);
    next_cycle();
    next_cycle();
    int_read(pool[3]);
    pad_request();
    next_cycle();
    next_cycle();

    // external op, internal read and internal write on three different banks
    cur_test = "concurrent";
    for (int n = 0; n < MIX_CYCLES; n++) begin
      base = int'(rand_bits(BANK_SEL_BITS));
      if (n % 2 == 0) begin
        ext_write(pool[pool_slot(base)], be_t'(rand_bits(BE_BITS)), rand_bits(WORD_BITS));
      end else begin
        ext_read(pool[pool_slot(base)]);
      end
      int_read(pool[pool_slot(base + 1)]);
      int_write(pool[pool_slot(base + 2)], rand_bits(WORD_BITS));
      next_cycle();
    end

    cur_test = "drain";
    repeat (TAIL_CYCLES) next_cycle();

    total = err_idle + err_vld + err_mdata + err_ext;
    $display("errors: idle %0d, valid %0d, mdata %0d, ext rdata %0d, total %0d",
             err_idle, err_vld, err_mdata, err_ext, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
source/iob_pkg.sv
source/iob_bank_if.sv
source/iob_port_arbiter.sv
source/iob_sram_bank.sv
source/iob_read_return.sv
source/io_buffer.sv
dv/tb_io_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the io_buffer testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_io_buffer

if ! verilator --binary --timing --assert \
    -f filelist.f \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -o "$TOP"; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG_FILE"; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0

// ==== source/io_buffer.sv ====
`timescale 1ns/1ps

module io_buffer (
  input  logic           i_clk,
  input  logic           i_rst_n,
  // external controller port
  input  iob_pkg::addr_t i_iob_bramctl_addr,
  input  logic           i_iob_bramctl_en,
  output iob_pkg::word_t o_iob_bramctl_rdata,
  input  iob_pkg::be_t   i_iob_bramctl_be,
  input  logic           i_iob_bramctl_we,
  input  iob_pkg::word_t i_iob_bramctl_wdata,
  // internal engine port
  input  iob_pkg::addr_t i_iob_raddr,
  input  logic           i_iob_rd_en,
  input  logic           i_iob_pad_en,
  input  iob_pkg::addr_t i_iob_waddr,
  input  logic           i_iob_wr_en,
  input  iob_pkg::word_t i_iob_wdat,
  output iob_pkg::word_t o_mdata,
  output logic           o_mdata_vld
);
  import iob_pkg::*;

  // bank port requests
  iob_bank_if bank_a [NUM_BANKS] ();
  iob_bank_if bank_b [NUM_BANKS] ();

  word_t rdata_a [NUM_BANKS];
  word_t rdata_b [NUM_BANKS];

  // ------------------------------
  // request steering
  // ------------------------------
  iob_port_arbiter u_arbiter (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_iob_bramctl_en    (i_iob_bramctl_en),
    .i_iob_bramctl_we    (i_iob_bramctl_we),
    .i_iob_bramctl_be    (i_iob_bramctl_be),
    .i_iob_bramctl_addr  (i_iob_bramctl_addr),
    .i_iob_bramctl_wdata (i_iob_bramctl_wdata),
    .i_iob_raddr         (i_iob_raddr),
    .i_iob_rd_en         (i_iob_rd_en),
    .i_iob_waddr         (i_iob_waddr),
    .i_iob_wr_en         (i_iob_wr_en),
    .i_iob_wdat          (i_iob_wdat),
    .bank_a              (bank_a),
    .bank_b              (bank_b)
  );

  // ------------------------------
  // memory banks
  // ------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    iob_sram_bank u_bank (
      .i_clk     (i_clk),
      .port_a    (bank_a[b]),
      .port_b    (bank_b[b]),
      .o_rdata_a (rdata_a[b]),
      .o_rdata_b (rdata_b[b])
    );
  end

  // read data back to both masters
  iob_read_return u_read_return (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_iob_rd_en         (i_iob_rd_en),
    .i_iob_pad_en        (i_iob_pad_en),
    .i_iob_raddr         (i_iob_raddr),
    .i_iob_bramctl_en    (i_iob_bramctl_en),
    .i_iob_bramctl_we    (i_iob_bramctl_we),
    .i_iob_bramctl_addr  (i_iob_bramctl_addr),
    .i_rdata_a           (rdata_a),
    .i_rdata_b           (rdata_b),
    .o_mdata             (o_mdata),
    .o_iob_bramctl_rdata (o_iob_bramctl_rdata),
    .o_mdata_vld         (o_mdata_vld)
  );

endmodule

// ==== source/iob_bank_if.sv ====
`timescale 1ns/1ps

interface iob_bank_if;
  import iob_pkg::*;

  // request to one bank port
  logic       en;
  logic       we;
  bank_addr_t addr;
  be_t        be;
  word_t      wdata;

  // arbiter side
  modport requester (
    output en,
    output we,
    output addr,
    output be,
    output wdata
  );

  // memory side
  modport bank (
    input en,
    input we,
    input addr,
    input be,
    input wdata
  );

endinterface

// ==== source/iob_pkg.sv ====
package iob_pkg;

  // ------------------------------
  // buffer geometry
  // ------------------------------

  // one buffer word and its byte lanes
  localparam int WORD_BITS      = 256;
  localparam int BE_BITS        = WORD_BITS / 8;

  // 4096 words, split into four banks by the top address bits
  localparam int ADDR_BITS      = 12;
  localparam int BANK_ADDR_BITS = 10;
  localparam int BANK_SEL_BITS  = ADDR_BITS - BANK_ADDR_BITS;
  localparam int NUM_BANKS      = 2 ** BANK_SEL_BITS;

  // ------------------------------
  // vector types
  // ------------------------------

  // data word
  typedef logic [WORD_BITS-1:0]      word_t;

  // byte enables, bit i covers byte i of the word
  typedef logic [BE_BITS-1:0]        be_t;

  // full buffer word address
  typedef logic [ADDR_BITS-1:0]      addr_t;

  // word address inside one bank
  typedef logic [BANK_ADDR_BITS-1:0] bank_addr_t;

  // bank index, upper address bits
  typedef logic [BANK_SEL_BITS-1:0]  bank_sel_t;

endpackage

// ==== source/iob_port_arbiter.sv ====
`timescale 1ns/1ps

module iob_port_arbiter (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // external controller port
  input  logic                 i_iob_bramctl_en,
  input  logic                 i_iob_bramctl_we,
  input  iob_pkg::be_t         i_iob_bramctl_be,
  input  iob_pkg::addr_t       i_iob_bramctl_addr,
  input  iob_pkg::word_t       i_iob_bramctl_wdata,
  // internal engine port
  input  iob_pkg::addr_t       i_iob_raddr,
  input  logic                 i_iob_rd_en,
  input  iob_pkg::addr_t       i_iob_waddr,
  input  logic                 i_iob_wr_en,
  input  iob_pkg::word_t       i_iob_wdat,
  // per-bank requests
  iob_bank_if.requester        bank_a [iob_pkg::NUM_BANKS],
  iob_bank_if.requester        bank_b [iob_pkg::NUM_BANKS]
);
  import iob_pkg::*;

  logic       ext_wr;
  logic       ext_rd;
  bank_sel_t  ext_bank;
  bank_sel_t  rd_bank;
  bank_sel_t  wr_bank;
  bank_addr_t ext_low;
  bank_addr_t rd_low;
  bank_addr_t wr_low;

  // ------------------------------
  // address split
  // ------------------------------
  assign ext_wr   = i_iob_bramctl_en & i_iob_bramctl_we;
  assign ext_rd   = i_iob_bramctl_en & ~i_iob_bramctl_we;

  assign ext_bank = i_iob_bramctl_addr[ADDR_BITS-1 -: BANK_SEL_BITS];
  assign rd_bank  = i_iob_raddr[ADDR_BITS-1 -: BANK_SEL_BITS];
  assign wr_bank  = i_iob_waddr[ADDR_BITS-1 -: BANK_SEL_BITS];

  assign ext_low  = i_iob_bramctl_addr[BANK_ADDR_BITS-1:0];
  assign rd_low   = i_iob_raddr[BANK_ADDR_BITS-1:0];
  assign wr_low   = i_iob_waddr[BANK_ADDR_BITS-1:0];

  // ------------------------------
  // per-bank steering
  // ------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic ext_wr_hit;
    logic ext_rd_hit;
    logic int_rd_hit;
    logic int_wr_hit;

    assign ext_wr_hit = ext_wr & (ext_bank == bank_sel_t'(b));
    assign ext_rd_hit = ext_rd & (ext_bank == bank_sel_t'(b));
    assign int_rd_hit = i_iob_rd_en & (rd_bank == bank_sel_t'(b));
    assign int_wr_hit = i_iob_wr_en & (wr_bank == bank_sel_t'(b));

    // port A: external write first, then internal read
    assign bank_a[b].en    = ext_wr_hit | int_rd_hit;
    assign bank_a[b].we    = ext_wr_hit;
    assign bank_a[b].addr  = ext_wr_hit ? ext_low : rd_low;
    assign bank_a[b].be    = i_iob_bramctl_be;
    assign bank_a[b].wdata = i_iob_bramctl_wdata;

    // port B: external read first, then internal write
    assign bank_b[b].en    = ext_rd_hit | int_wr_hit;
    assign bank_b[b].we    = int_wr_hit & ~ext_rd_hit;
    assign bank_b[b].addr  = ext_rd_hit ? ext_low : wr_low;
    assign bank_b[b].be    = '1;
    assign bank_b[b].wdata = i_iob_wdat;
  end

  // ------------------------------
  // master collisions
  // ------------------------------

  // external write and internal read fight for port A of one bank
  a_porta_clash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(ext_wr && i_iob_rd_en && (ext_bank == rd_bank)))
    else $error("iob arbiter: ext write and int read hit bank %0d", ext_bank);

  // external read and internal write fight for port B
  a_portb_clash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(ext_rd && i_iob_wr_en && (ext_bank == wr_bank)))
    else $error("iob arbiter: ext read and int write hit bank %0d", ext_bank);

endmodule

// ==== source/iob_read_return.sv ====
`timescale 1ns/1ps

module iob_read_return (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // request side sampled at the request edge
  input  logic                 i_iob_rd_en,
  input  logic                 i_iob_pad_en,
  input  iob_pkg::addr_t       i_iob_raddr,
  input  logic                 i_iob_bramctl_en,
  input  logic                 i_iob_bramctl_we,
  input  iob_pkg::addr_t       i_iob_bramctl_addr,
  // bank read data
  input  iob_pkg::word_t       i_rdata_a [iob_pkg::NUM_BANKS],
  input  iob_pkg::word_t       i_rdata_b [iob_pkg::NUM_BANKS],
  // returned words
  output iob_pkg::word_t       o_mdata,
  output iob_pkg::word_t       o_iob_bramctl_rdata,
  output logic                 o_mdata_vld
);
  import iob_pkg::*;

  bank_sel_t int_bank_q;
  bank_sel_t ext_bank_q;
  logic      int_rd_q;
  logic      pad_q;
  logic      ext_rd_q;

  // ------------------------------
  // request tracking
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      int_bank_q <= '0;
      ext_bank_q <= '0;
      int_rd_q   <= 1'b0;
      pad_q      <= 1'b0;
      ext_rd_q   <= 1'b0;
    end else begin
      // pad wins over a read in the same cycle
      int_rd_q <= i_iob_rd_en & ~i_iob_pad_en;
      pad_q    <= i_iob_pad_en;
      ext_rd_q <= i_iob_bramctl_en & ~i_iob_bramctl_we;

      if (i_iob_rd_en) begin
        int_bank_q <= i_iob_raddr[ADDR_BITS-1 -: BANK_SEL_BITS];
      end
      if (i_iob_bramctl_en) begin
        ext_bank_q <= i_iob_bramctl_addr[ADDR_BITS-1 -: BANK_SEL_BITS];
      end
    end
  end

  // ------------------------------
  // data select
  // ------------------------------

  // internal reads come back on port A, external reads on port B
  assign o_mdata             = int_rd_q ? i_rdata_a[int_bank_q] : '0;
  assign o_iob_bramctl_rdata = ext_rd_q ? i_rdata_b[ext_bank_q] : '0;
  assign o_mdata_vld         = int_rd_q | pad_q;

endmodule

// ==== source/iob_sram_bank.sv ====
`timescale 1ns/1ps

module iob_sram_bank (
  input  logic           i_clk,
  iob_bank_if.bank       port_a,
  iob_bank_if.bank       port_b,
  output iob_pkg::word_t o_rdata_a,
  output iob_pkg::word_t o_rdata_b
);
  import iob_pkg::*;

  localparam int DEPTH = 2 ** BANK_ADDR_BITS;

  word_t mem [DEPTH];
  word_t rdata_a_q;
  word_t rdata_b_q;

  // ------------------------------
  // array access
  // ------------------------------
  always_ff @(posedge i_clk) begin
    // port A, byte lanes under be
    if (port_a.en && port_a.we) begin
      for (int i = 0; i < BE_BITS; i++) begin
        if (port_a.be[i]) begin
          mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
        end
      end
    end

    // port B, whole word
    if (port_b.en && port_b.we) begin
      mem[port_b.addr] <= port_b.wdata;
    end

    // read data, old contents on a same-edge write
    if (port_a.en && !port_a.we) begin
      rdata_a_q <= mem[port_a.addr];
    end
    if (port_b.en && !port_b.we) begin
      rdata_b_q <= mem[port_b.addr];
    end
  end

  assign o_rdata_a = rdata_a_q;
  assign o_rdata_b = rdata_b_q;

  // both masters writing one word in the same cycle leaves it undefined
  a_dual_write: assert property (@(posedge i_clk)
    !(port_a.en && port_a.we && port_b.en && port_b.we &&
      (port_a.addr == port_b.addr)))
    else $error("iob bank: both ports write address %0h", port_a.addr);

endmodule
